/* project.f */
src/cpu_pkg.sv
src/cpuCtrlIf.sv
src/ctrlDecode.sv
src/regFile.sv
src/alu.sv
src/branchEval.sv
src/fetchUnit.sv
src/dataMem.sv
src/cpu.sv
tb/cpu_chk.sv
tb/cpuMonitor.sv
tb/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module tb_cpu -Mdir "$buildDir" -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/Vtb_cpu" +verilator+error+limit+100 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^Test passed$" "$logFile"; then
  exit 0
fi
exit 1

/* tb/tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
  parameter int halfPeriod = 2
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(halfPeriod) clk = ~clk;

endmodule

module tb_cpu;

  localparam int clkPeriod   = 4;
  localparam int progWords   = 25;
  localparam int numRows     = 23;
  localparam int resetCycles = (progWords > 10) ? progWords : 10;  // Boot load fits in reset.
  localparam int timeoutNs   = (numRows + 20) * clkPeriod + (resetCycles + 1) * clkPeriod;

  logic                              clk;
  logic                              arstN;
  logic                              bootWe;
  logic [cpu_pkg::imemAddrWidth-1:0] bootAddr;
  logic [cpu_pkg::dataWidth-1:0]     bootData;
  logic [cpu_pkg::dataWidth-1:0]     pc;
  logic                              hlt;
  logic                              wbEn;
  logic [cpu_pkg::regAddrWidth-1:0]  wbReg;
  logic [cpu_pkg::dataWidth-1:0]     wbData;
  logic [cpu_pkg::dataWidth-1:0]     progMem [cpu_pkg::imemDepth];
  logic [37:0]                       expRows [numRows];  // {pc, hlt, wbEn, wbReg, wbData}.
  logic [cpu_pkg::imemAddrWidth-1:0] loadAddr;
  logic                              monDone;
  int                                monErrs;
  int                                assertFails;

  tbClock #(.halfPeriod(clkPeriod / 2)) i_tbClock (.clk(clk));

  cpu i_cpu (
    .clk(clk), .arstN(arstN), .bootWe(bootWe), .bootAddr(bootAddr), .bootData(bootData),
    .pc(pc), .hlt(hlt), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData));

  cpuMonitor #(.numRows(numRows)) i_cpuMonitor (
    .clk(clk), .arstN(arstN), .pc(pc), .hlt(hlt), .wbEn(wbEn), .wbReg(wbReg),
    .wbData(wbData), .expRows(expRows), .done(monDone), .errCount(monErrs));

  function automatic logic [37:0] makeRow(input logic [15:0] rowPc, input logic rowHlt,
                                          input logic rowEn, input logic [3:0] rowReg,
                                          input logic [15:0] rowData);
    return {rowPc, rowHlt, rowEn, rowReg, rowData};
  endfunction

  // Word index, then pc and instruction in the comment.
  task automatic fillProgram();
    progMem[8'd0]  = 16'hA1F0;  // 00 LLB r1, 0xF0.
    progMem[8'd1]  = 16'hB17F;  // 02 LHB r1, 0x7F.
    progMem[8'd2]  = 16'hA220;  // 04 LLB r2, 0x20.
    progMem[8'd3]  = 16'h0312;  // 06 ADD r3, r1, r2.
    progMem[8'd4]  = 16'hCC01;  // 08 B OVF, +1.
    progMem[8'd5]  = 16'hAFEE;  // 0A Skipped.
    progMem[8'd6]  = 16'h1431;  // 0C SUB r4, r3, r1.
    progMem[8'd7]  = 16'h2532;  // 0E XOR r5, r3, r2.
    progMem[8'd8]  = 16'hA681;  // 10 LLB r6, 0x81.
    progMem[8'd9]  = 16'hB6F0;  // 12 LHB r6, 0xF0.
    progMem[8'd10] = 16'h3764;  // 14 SLL r7, r6, 4.
    progMem[8'd11] = 16'h4863;  // 16 SRA r8, r6, 3.
    progMem[8'd12] = 16'hA940;  // 18 LLB r9, 0x40.
    progMem[8'd13] = 16'h9592;  // 1A SW r5, 2(r9).
    progMem[8'd14] = 16'h8A92;  // 1C LW r10, 2(r9).
    progMem[8'd15] = 16'h1BA5;  // 1E SUB r11, r10, r5.
    progMem[8'd16] = 16'hC201;  // 20 B EQ, +1.
    progMem[8'd17] = 16'hAFEE;  // 22 Skipped.
    progMem[8'd18] = 16'hC005;  // 24 B NEQ, +5.
    progMem[8'd19] = 16'hAC2E;  // 26 LLB r12, 0x2E.
    progMem[8'd20] = 16'hDEC0;  // 28 BR UNCOND, r12.
    progMem[8'd21] = 16'hAFEE;  // 2A Skipped.
    progMem[8'd22] = 16'hAFEE;  // 2C Skipped.
    progMem[8'd23] = 16'hED00;  // 2E PCS r13.
    progMem[8'd24] = 16'hF000;  // 30 HLT.
  endtask

  // Rows in execution order.
  task automatic fillExpected();
    expRows[0]  = makeRow(16'h0000, 1'b0, 1'b1, 4'd1,  16'h00F0);
    expRows[1]  = makeRow(16'h0002, 1'b0, 1'b1, 4'd1,  16'h7FF0);
    expRows[2]  = makeRow(16'h0004, 1'b0, 1'b1, 4'd2,  16'h0020);
    expRows[3]  = makeRow(16'h0006, 1'b0, 1'b1, 4'd3,  16'h7FFF);  // Saturated.
    expRows[4]  = makeRow(16'h0008, 1'b0, 1'b0, 4'd0,  16'h0000);  // OVF taken.
    expRows[5]  = makeRow(16'h000C, 1'b0, 1'b1, 4'd4,  16'h000F);
    expRows[6]  = makeRow(16'h000E, 1'b0, 1'b1, 4'd5,  16'h7FDF);
    expRows[7]  = makeRow(16'h0010, 1'b0, 1'b1, 4'd6,  16'h0081);
    expRows[8]  = makeRow(16'h0012, 1'b0, 1'b1, 4'd6,  16'hF081);
    expRows[9]  = makeRow(16'h0014, 1'b0, 1'b1, 4'd7,  16'h0810);
    expRows[10] = makeRow(16'h0016, 1'b0, 1'b1, 4'd8,  16'hFE10);  // Sign fill.
    expRows[11] = makeRow(16'h0018, 1'b0, 1'b1, 4'd9,  16'h0040);
    expRows[12] = makeRow(16'h001A, 1'b0, 1'b0, 4'd0,  16'h0000);  // SW.
    expRows[13] = makeRow(16'h001C, 1'b0, 1'b1, 4'd10, 16'h7FDF);  // LW reads it back.
    expRows[14] = makeRow(16'h001E, 1'b0, 1'b1, 4'd11, 16'h0000);
    expRows[15] = makeRow(16'h0020, 1'b0, 1'b0, 4'd0,  16'h0000);  // EQ taken.
    expRows[16] = makeRow(16'h0024, 1'b0, 1'b0, 4'd0,  16'h0000);  // NEQ falls through.
    expRows[17] = makeRow(16'h0026, 1'b0, 1'b1, 4'd12, 16'h002E);
    expRows[18] = makeRow(16'h0028, 1'b0, 1'b0, 4'd0,  16'h0000);  // BR to 0x2E.
    expRows[19] = makeRow(16'h002E, 1'b0, 1'b1, 4'd13, 16'h0030);
    expRows[20] = makeRow(16'h0030, 1'b1, 1'b0, 4'd0,  16'h0000);
    expRows[21] = makeRow(16'h0030, 1'b1, 1'b0, 4'd0,  16'h0000);
    expRows[22] = makeRow(16'h0030, 1'b1, 1'b0, 4'd0,  16'h0000);
  endtask

  initial begin
    arstN    = 1'b0;
    bootWe   = 1'b0;
    bootAddr = '0;
    bootData = '0;
    loadAddr = '0;
    fillProgram();
    fillExpected();
    repeat (progWords) begin
      @(posedge clk);
      #1;
      bootWe   = 1'b1;
      bootAddr = loadAddr;
      bootData = progMem[loadAddr];
      loadAddr = loadAddr + 1'b1;
    end
    repeat (resetCycles - progWords + 1) begin  // First edge takes the last word.
      @(posedge clk);
      #1;
      bootWe = 1'b0;
    end
    arstN = 1'b1;
    wait (monDone === 1'b1);
    @(negedge clk);
    assertFails = i_cpu.i_cpuChk.pcFails + i_cpu.i_cpuChk.haltFails +
                  i_cpu.i_cpuChk.resetFails;
    if (monErrs == 0 && assertFails == 0) begin
      $display("Test passed");
    end else begin
      $display("%0d assertion failures", assertFails);
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    #(timeoutNs);
    $display("ERROR: CPU did not halt within %0d ns", timeoutNs);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/cpuMonitor.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuMonitor #(
  parameter int numRows = 1
) (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic [cpu_pkg::dataWidth-1:0]    pc,
  input  logic                             hlt,
  input  logic                             wbEn,
  input  logic [cpu_pkg::regAddrWidth-1:0] wbReg,
  input  logic [cpu_pkg::dataWidth-1:0]    wbData,
  input  logic [37:0]                      expRows [numRows],
  output logic                             done,
  output int                               errCount
);

  localparam int idxWidth = $clog2(numRows);

  logic [idxWidth-1:0] rowIdx;
  logic [37:0]         row;
  int                  rowErrs;

  task automatic compareField(input string name, input logic [15:0] expVal,
                              input logic [15:0] gotVal);
    if (gotVal !== expVal) begin
      $display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name, expVal, gotVal);
      rowErrs++;
    end
  endtask

  // Retire outputs still show the instruction that this edge retires.
  always @(posedge clk) begin
    if (!arstN) begin
      rowIdx   = '0;
      errCount = 0;
      done     = 1'b0;
    end else if (!done) begin
      row     = expRows[rowIdx];
      rowErrs = 0;
      compareField("pc", row[37:22], pc);
      compareField("hlt", {15'd0, row[21]}, {15'd0, hlt});
      compareField("wbEn", {15'd0, row[20]}, {15'd0, wbEn});
      if (row[20]) begin  // Register and data matter only on a write.
        compareField("wbReg", {12'd0, row[19:16]}, {12'd0, wbReg});
        compareField("wbData", row[15:0], wbData);
      end
      $display("Row %0d at pc %h: %s", rowIdx, pc, (rowErrs == 0) ? "ok" : "wrong");
      errCount = errCount + rowErrs;
      if (int'(rowIdx) == numRows - 1) begin
        $display("Checked %0d rows, %0d mismatches", numRows, errCount);
        done = 1'b1;
      end else begin
        rowIdx = rowIdx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/cpu_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_chk (
  input logic                          clk,
  input logic                          arstN,
  input logic [cpu_pkg::dataWidth-1:0] pc,
  input logic                          hlt,
  input logic                          wbEn
);

  int pcFails    = 0;
  int haltFails  = 0;
  int resetFails = 0;

  pcEven: assert property (@(posedge clk) disable iff (!arstN) !pc[0])
    else begin
      $error("pc %h is not word aligned", pc);
      pcFails++;
    end

  // HLT parks the core for good.
  haltHolds: assert property (@(posedge clk) disable iff (!arstN)
                              hlt |=> (hlt && $stable(pc)))
    else begin
      $error("core left the halted state or pc moved");
      haltFails++;
    end

  // Reset state of the core as seen on the retire ports.
  quietInReset: assert property (@(posedge clk)
                                 !arstN |-> (!wbEn && !hlt && (pc == '0)))
    else begin
      $error("core not in its reset state during reset");
      resetFails++;
    end

endmodule

bind cpu cpu_chk i_cpuChk (.clk(clk), .arstN(arstN), .pc(pc), .hlt(hlt), .wbEn(wbEn));

`default_nettype wire

/* src/cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu (
  input  logic                              clk,
  input  logic                              arstN,
  input  logic                              bootWe,
  input  logic [cpu_pkg::imemAddrWidth-1:0] bootAddr,
  input  logic [cpu_pkg::dataWidth-1:0]     bootData,
  output logic [cpu_pkg::dataWidth-1:0]     pc,
  output logic                              hlt,
  output logic                              wbEn,
  output logic [cpu_pkg::regAddrWidth-1:0]  wbReg,
  output logic [cpu_pkg::dataWidth-1:0]     wbData
);

  logic [cpu_pkg::dataWidth-1:0]    instr;
  logic [cpu_pkg::dataWidth-1:0]    pcPlus2;
  logic [cpu_pkg::regAddrWidth-1:0] rdAddr2;
  logic [cpu_pkg::dataWidth-1:0]    rdData1;
  logic [cpu_pkg::dataWidth-1:0]    rdData2;
  logic [cpu_pkg::dataWidth-1:0]    aluResult;
  logic [cpu_pkg::dataWidth-1:0]    memData;
  logic [cpu_pkg::dataWidth-1:0]    target;
  cpu_pkg::flagsT                   flags;
  logic                             flagsWe;
  logic                             taken;

  cpuCtrlIf ctrlBus ();

  // SW, the byte loads and BR read the destination field as a source.
  assign rdAddr2 = (ctrlBus.op == cpu_pkg::SW  || ctrlBus.op == cpu_pkg::LLB ||
                    ctrlBus.op == cpu_pkg::LHB || ctrlBus.op == cpu_pkg::BR) ?
                   instr[11:8] : instr[3:0];

  ctrlDecode i_ctrlDecode (.instr(instr), .ctrl(ctrlBus));

  regFile i_regFile (
    .clk(clk), .arstN(arstN), .rdAddr1(instr[7:4]), .rdAddr2(rdAddr2),
    .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData),
    .rdData1(rdData1), .rdData2(rdData2));

  alu i_alu (
    .ctrl(ctrlBus), .srcA(rdData1), .srcB(rdData2),
    .result(aluResult), .flags(flags), .flagsWe(flagsWe));

  // BR jumps to the register in the rs field.
  branchEval i_branchEval (
    .clk(clk), .arstN(arstN), .ctrl(ctrlBus), .flags(flags), .flagsWe(flagsWe),
    .pcPlus2(pcPlus2), .regTarget(rdData1), .taken(taken), .target(target));

  fetchUnit i_fetchUnit (
    .clk(clk), .arstN(arstN), .ctrl(ctrlBus), .taken(taken), .target(target),
    .bootWe(bootWe), .bootAddr(bootAddr), .bootData(bootData),
    .pc(pc), .pcPlus2(pcPlus2), .instr(instr));

  // Boot traffic at pc 0 must not reach data memory.
  dataMem i_dataMem (
    .clk(clk), .rdEn(ctrlBus.memRead), .wrEn(ctrlBus.memWrite && arstN),
    .addr(aluResult), .wrData(rdData2), .rdData(memData));

  always_comb begin
    case (ctrlBus.wbSrc)
      cpu_pkg::MEM:    wbData = memData;
      cpu_pkg::PCNEXT: wbData = pcPlus2;  // PCS.
      default:         wbData = aluResult;
    endcase
  end

  assign wbReg = instr[11:8];
  assign wbEn  = ctrlBus.regWrite && arstN;  // Quiet while booting.
  assign hlt   = ctrlBus.halt && arstN;

endmodule

`default_nettype wire

/* src/dataMem.sv */
`timescale 1ns/10ps
`default_nettype none

module dataMem (
  input  logic                          clk,
  input  logic                          rdEn,
  input  logic                          wrEn,
  input  logic [cpu_pkg::dataWidth-1:0] addr,
  input  logic [cpu_pkg::dataWidth-1:0] wrData,
  output logic [cpu_pkg::dataWidth-1:0] rdData
);

  logic [cpu_pkg::dataWidth-1:0]     mem [cpu_pkg::dmemDepth];
  logic [cpu_pkg::dmemAddrWidth-1:0] wordIdx;

  assign wordIdx = addr[cpu_pkg::dmemAddrWidth:1];  // Drop the byte bit.

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wordIdx] <= wrData;
    end
  end

  assign rdData = rdEn ? mem[wordIdx] : '0;

endmodule

`default_nettype wire

/* src/fetchUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchUnit (
  input  logic                              clk,
  input  logic                              arstN,
  cpuCtrlIf.fe                              ctrl,
  input  logic                              taken,
  input  logic [cpu_pkg::dataWidth-1:0]     target,
  input  logic                              bootWe,
  input  logic [cpu_pkg::imemAddrWidth-1:0] bootAddr,
  input  logic [cpu_pkg::dataWidth-1:0]     bootData,
  output logic [cpu_pkg::dataWidth-1:0]     pc,
  output logic [cpu_pkg::dataWidth-1:0]     pcPlus2,
  output logic [cpu_pkg::dataWidth-1:0]     instr
);

  logic [cpu_pkg::dataWidth-1:0] imem [cpu_pkg::imemDepth];
  logic [cpu_pkg::dataWidth-1:0] pcNext;

  // Boot loader writes here while the core sits in reset.
  always_ff @(posedge clk) begin
    if (bootWe) begin
      imem[bootAddr] <= bootData;
    end
  end

  assign instr   = imem[pc[cpu_pkg::imemAddrWidth:1]];  // Byte address to word.
  assign pcPlus2 = pc + 16'd2;

  always_comb begin
    if (ctrl.halt) begin
      pcNext = pc;  // Park on HLT.
    end else if (taken) begin
      pcNext = target;
    end else begin
      pcNext = pcPlus2;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

/* src/branchEval.sv */
`timescale 1ns/10ps
`default_nettype none

module branchEval (
  input  logic                          clk,
  input  logic                          arstN,
  cpuCtrlIf.br                          ctrl,
  input  cpu_pkg::flagsT                flags,
  input  logic                          flagsWe,
  input  logic [cpu_pkg::dataWidth-1:0] pcPlus2,
  input  logic [cpu_pkg::dataWidth-1:0] regTarget,
  output logic                          taken,
  output logic [cpu_pkg::dataWidth-1:0] target
);

  cpu_pkg::flagsT flagReg;
  logic           condMet;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagReg <= '0;
    end else if (flagsWe) begin
      flagReg.z <= flags.z;
      if (ctrl.op != cpu_pkg::XOR) begin  // XOR leaves V and N alone.
        flagReg.v <= flags.v;
        flagReg.n <= flags.n;
      end
    end
  end

  always_comb begin
    case (ctrl.cond)
      cpu_pkg::NEQ: condMet = !flagReg.z;
      cpu_pkg::EQ:  condMet = flagReg.z;
      cpu_pkg::GT:  condMet = !flagReg.z && !flagReg.n;
      cpu_pkg::LT:  condMet = flagReg.n;
      cpu_pkg::GE:  condMet = flagReg.z || (!flagReg.z && !flagReg.n);
      cpu_pkg::LE:  condMet = flagReg.n || flagReg.z;
      cpu_pkg::OVF: condMet = flagReg.v;
      default:      condMet = 1'b1;  // Unconditional.
    endcase
  end

  assign taken  = (ctrl.isBranch || ctrl.isBranchReg) && condMet;
  assign target = ctrl.isBranchReg ? regTarget : pcPlus2 + ctrl.imm;

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
  cpuCtrlIf.exe                         ctrl,
  input  logic [cpu_pkg::dataWidth-1:0] srcA,
  input  logic [cpu_pkg::dataWidth-1:0] srcB,
  output logic [cpu_pkg::dataWidth-1:0] result,
  output cpu_pkg::flagsT                flags,
  output logic                          flagsWe
);

  logic [cpu_pkg::dataWidth-1:0] opB;
  logic [cpu_pkg::dataWidth-1:0] sum;
  logic [cpu_pkg::dataWidth-1:0] diff;
  logic [cpu_pkg::dataWidth-1:0] satVal;
  logic                          sumOvf;
  logic                          diffOvf;
  logic                          ovf;

  assign opB  = ctrl.aluSrcImm ? ctrl.imm : srcB;
  assign sum  = srcA + opB;
  assign diff = srcA - opB;

  // Signed overflow checks.
  assign sumOvf  = (srcA[cpu_pkg::dataMsb] == opB[cpu_pkg::dataMsb]) &&
                   (sum[cpu_pkg::dataMsb] != srcA[cpu_pkg::dataMsb]);
  assign diffOvf = (srcA[cpu_pkg::dataMsb] != opB[cpu_pkg::dataMsb]) &&
                   (diff[cpu_pkg::dataMsb] != srcA[cpu_pkg::dataMsb]);

  // Overflow always clips toward the sign of srcA.
  assign satVal = srcA[cpu_pkg::dataMsb] ? {1'b1, {cpu_pkg::dataMsb{1'b0}}} :
                                           {1'b0, {cpu_pkg::dataMsb{1'b1}}};

  always_comb begin
    result = sum;
    ovf    = 1'b0;
    case (ctrl.op)
      cpu_pkg::ADD: begin
        result = sumOvf ? satVal : sum;
        ovf    = sumOvf;
      end
      cpu_pkg::SUB: begin
        result = diffOvf ? satVal : diff;
        ovf    = diffOvf;
      end
      cpu_pkg::XOR: result = srcA ^ opB;
      cpu_pkg::SLL: result = srcA << opB[3:0];
      cpu_pkg::SRA: result = $signed(srcA) >>> opB[3:0];  // Sign fill.
      cpu_pkg::LLB: result = {srcB[15:8], ctrl.imm[7:0]};
      cpu_pkg::LHB: result = {ctrl.imm[7:0], srcB[7:0]};
      default:      result = sum;  // Address for LW and SW.
    endcase
  end

  assign flags.z = (result == '0);
  assign flags.v = ovf;
  assign flags.n = result[cpu_pkg::dataMsb];
  assign flagsWe = (ctrl.op == cpu_pkg::ADD) || (ctrl.op == cpu_pkg::SUB) ||
                   (ctrl.op == cpu_pkg::XOR);

endmodule

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  logic                             clk,
  input  logic                             arstN,
  input  logic [cpu_pkg::regAddrWidth-1:0] rdAddr1,
  input  logic [cpu_pkg::regAddrWidth-1:0] rdAddr2,
  input  logic                             wrEn,
  input  logic [cpu_pkg::regAddrWidth-1:0] wrAddr,
  input  logic [cpu_pkg::dataWidth-1:0]    wrData,
  output logic [cpu_pkg::dataWidth-1:0]    rdData1,
  output logic [cpu_pkg::dataWidth-1:0]    rdData2
);

  logic [cpu_pkg::dataWidth-1:0] regs [2**cpu_pkg::regAddrWidth];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 2**cpu_pkg::regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;  // r0 is never written.
    end
  end

  // A write lands on the retiring edge, so the next instruction
  // already reads the new value.
  assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

`default_nettype wire

/* src/ctrlDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module ctrlDecode (
  input logic [cpu_pkg::dataWidth-1:0] instr,
  cpuCtrlIf.dec                        ctrl
);

  cpu_pkg::opcodeE op;

  assign op = cpu_pkg::opcodeE'(instr[15:12]);

  always_comb begin
    ctrl.op          = op;
    ctrl.aluSrcImm   = 1'b0;
    ctrl.regWrite    = 1'b0;
    ctrl.memRead     = 1'b0;
    ctrl.memWrite    = 1'b0;
    ctrl.wbSrc       = cpu_pkg::ALU;
    ctrl.isBranch    = 1'b0;
    ctrl.isBranchReg = 1'b0;
    ctrl.cond        = cpu_pkg::condE'(instr[11:9]);
    ctrl.imm         = '0;
    ctrl.halt        = 1'b0;
    case (op)
      cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::XOR: begin
        ctrl.regWrite = 1'b1;
      end
      cpu_pkg::SLL, cpu_pkg::SRA: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.imm       = {12'h000, instr[3:0]};  // Shift amount.
      end
      cpu_pkg::LW, cpu_pkg::SW: begin
        ctrl.regWrite  = (op == cpu_pkg::LW);
        ctrl.memRead   = (op == cpu_pkg::LW);
        ctrl.memWrite  = (op == cpu_pkg::SW);
        ctrl.aluSrcImm = 1'b1;
        ctrl.wbSrc     = cpu_pkg::MEM;
        ctrl.imm       = {{11{instr[3]}}, instr[3:0], 1'b0};  // Word offset in bytes.
      end
      cpu_pkg::LLB, cpu_pkg::LHB: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.imm       = {8'h00, instr[7:0]};
      end
      cpu_pkg::B: begin
        ctrl.isBranch = 1'b1;
        ctrl.imm      = {{6{instr[8]}}, instr[8:0], 1'b0};
      end
      cpu_pkg::BR:  ctrl.isBranchReg = 1'b1;
      cpu_pkg::PCS: begin
        ctrl.regWrite = 1'b1;
        ctrl.wbSrc    = cpu_pkg::PCNEXT;
      end
      cpu_pkg::HLT: ctrl.halt = 1'b1;
      default: ;  // Unused codes retire with no effect.
    endcase
  end

endmodule

`default_nettype wire

/* src/cpuCtrlIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface cpuCtrlIf;
  cpu_pkg::opcodeE               op;
  logic                          aluSrcImm;
  logic                          regWrite;
  logic                          memRead;
  logic                          memWrite;
  cpu_pkg::wbSrcE                wbSrc;
  logic                          isBranch;
  logic                          isBranchReg;
  cpu_pkg::condE                 cond;
  logic [cpu_pkg::dataWidth-1:0] imm;  // Already sign extended and scaled.
  logic                          halt;

  modport dec (output op, aluSrcImm, regWrite, memRead, memWrite, wbSrc,
               isBranch, isBranchReg, cond, imm, halt);
  modport exe (input op, aluSrcImm, imm);
  modport br  (input op, isBranch, isBranchReg, cond, imm);
  modport fe  (input halt);
endinterface

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // Datapath and register file sizes.
  localparam int dataWidth    = 16;
  localparam int dataMsb      = dataWidth - 1;
  localparam int regAddrWidth = 4;

  // Memory sizes in 16-bit words.
  localparam int imemDepth     = 256;
  localparam int imemAddrWidth = 8;
  localparam int dmemDepth     = 256;
  localparam int dmemAddrWidth = 8;

  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    XOR = 4'd2,
    SLL = 4'd3,
    SRA = 4'd4,
    LW  = 4'd8,
    SW  = 4'd9,
    LLB = 4'd10,
    LHB = 4'd11,
    B   = 4'd12,
    BR  = 4'd13,
    PCS = 4'd14,
    HLT = 4'd15
  } opcodeE;  // Codes 5 to 7 are no operation.

  typedef enum logic [2:0] {
    NEQ    = 3'd0,
    EQ     = 3'd1,
    GT     = 3'd2,
    LT     = 3'd3,
    GE     = 3'd4,
    LE     = 3'd5,
    OVF    = 3'd6,
    UNCOND = 3'd7
  } condE;

  typedef enum logic [1:0] {
    ALU    = 2'd0,
    MEM    = 2'd1,
    PCNEXT = 2'd2
  } wbSrcE;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flagsT;

endpackage

`default_nettype wire
